//--- compile.f
logic/rr_csr_pkg.sv
logic/csr_write_if.sv
logic/lib_pipe.sv
logic/axil_write_capture.sv
logic/csr_file.sv
logic/axil_read_port.sv
logic/rr_csr_top.sv
dv/rr_csr_props.sv
dv/tb_rr_csr.sv

//--- Bender.yml
package:
  name: rr_csr

sources:
  - logic/rr_csr_pkg.sv
  - logic/csr_write_if.sv
  - logic/lib_pipe.sv
  - logic/axil_write_capture.sv
  - logic/csr_file.sv
  - logic/axil_read_port.sv
  - logic/rr_csr_top.sv
  - target: test
    files:
      - dv/rr_csr_props.sv
      - dv/tb_rr_csr.sv

//--- dv/tb_rr_csr.sv
`timescale 1ns/1ps

module tb_rr_csr;
    import rr_csr_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int RAND_WRITES = 24;
    localparam int STALL_OPS = 40;

    logic clk;
    logic rstn;
    logic awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    logic [31:0] awaddr_i, araddr_i, wdata_i, rdata_o;
    logic [3:0] wstrb_i;
    logic [1:0] bresp_o, rresp_o;
    status_t status_i;
    rr_mode_t mode_o;
    storage_cfg_t cfg_o;

    logic [31:0] lfsr = 32'd10;
    logic [31:0] model [CSR_CNT];
    bit stall_en;
    int errors, tests, tests_failed, test_errs;
    int bu_cnt, ff_cnt;

    rr_csr_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // command pulses are counted mid-cycle
    always @(negedge clk) begin
        if (cfg_o.buf_update) bu_cnt++;
        if (cfg_o.force_finish) ff_cnt++;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic ready_bit();
        return stall_en ? take_bits(1) : 1'b1;
    endfunction

    // only the host slots store data, bytes with a clear strobe keep their value
    function automatic void model_write(input logic [3:0] idx, input logic [31:0] data,
                                        input logic [3:0] strb);
        if (idx <= ON_THE_FLY_BALANCE) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("ERR %s got %0h expected %0h", name, got, exp);
        errors++;
    endtask

    task automatic end_run();
        errors += DUT.u_props.assert_fails;
        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        end_run();
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_errs) tests_failed++;
        $display("test %s: %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    task automatic axil_write(input logic [3:0] idx, input logic [31:0] data,
                              input logic [3:0] strb, input int order);
        int n;
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        n = 0;
        @(posedge clk);
        awaddr_i <= {26'd0, idx, 2'b00};
        wdata_i <= data;
        wstrb_i <= strb;
        // order 0 sends AW first, 1 sends W first, 2 sends both together
        awvalid_i <= (order != 1);
        wvalid_i <= (order != 0);
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid_i && awready_o) begin
                aw_done = 1'b1;
                awvalid_i <= 1'b0;
            end
            if (wvalid_i && wready_o) begin
                w_done = 1'b1;
                wvalid_i <= 1'b0;
            end
            if (aw_done && !w_done) wvalid_i <= 1'b1;
            if (w_done && !aw_done) awvalid_i <= 1'b1;
            if (++n > TIMEOUT) wait_timeout("awready_o and wready_o");
        end
        n = 0;
        do begin
            bready_i <= ready_bit();
            @(posedge clk);
            if (++n > TIMEOUT) wait_timeout("bvalid_o");
        end while (!(bvalid_o && bready_i));
        if (bresp_o !== 2'b00) report_mismatch("bresp_o", bresp_o, 2'b00);
        bready_i <= 1'b0;
        @(posedge clk);
        if (bvalid_o) begin
            $display("a second B response came for a single write");
            errors++;
        end
    endtask

    task automatic axil_read(input logic [3:0] idx, output logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        araddr_i <= {26'd0, idx, 2'b00};
        arvalid_i <= 1'b1;
        do begin
            @(posedge clk);
            if (++n > TIMEOUT) wait_timeout("arready_o");
        end while (!arready_o);
        arvalid_i <= 1'b0;
        n = 0;
        do begin
            rready_i <= ready_bit();
            @(posedge clk);
            if (++n > TIMEOUT) wait_timeout("rvalid_o");
        end while (!(rvalid_o && rready_i));
        data = rdata_o;
        if (rresp_o !== 2'b00) report_mismatch("rresp_o", rresp_o, 2'b00);
        rready_i <= 1'b0;
        @(posedge clk);
        if (rvalid_o) begin
            $display("a second R response came for a single read");
            errors++;
        end
    endtask

    task automatic read_check(input logic [3:0] idx);
        logic [31:0] data;
        axil_read(idx, data);
        if (data !== model[idx]) begin
            report_mismatch($sformatf("rdata_o[%0d]", idx), data, model[idx]);
        end
    endtask

    task automatic check_outputs();
        rr_mode_t exp_mode;
        storage_cfg_t exp_cfg;
        exp_mode = {model[RR_MODE][0], model[RR_MODE][1], model[RR_MODE][2]};
        exp_cfg = {model[BUF_ADDR_HI], model[BUF_ADDR_LO], model[BUF_SIZE_HI],
                   model[BUF_SIZE_LO], model[ON_THE_FLY_BALANCE], 2'b00};
        if (mode_o !== exp_mode) report_mismatch("mode_o", mode_o, exp_mode);
        if (cfg_o !== exp_cfg) report_mismatch("cfg_o", cfg_o, exp_cfg);
    endtask

    task automatic drive_status();
        status_t s;
        s.record_bits[63:32] = take_bits(32);
        s.record_bits[31:0] = take_bits(32);
        s.rr_state = take_bits(32);
        @(posedge clk);
        status_i <= s;
        model[RECORD_BITS_LO] = s.record_bits[31:0];
        model[RECORD_BITS_HI] = s.record_bits[63:32];
        model[RR_STATE] = s.rr_state;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        logic [3:0] idx;
        logic [31:0] data;
        logic [3:0] strb;
        int n;
        rstn = 1'b0;
        awvalid_i = 1'b0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        awaddr_i = '0;
        araddr_i = '0;
        wdata_i = '0;
        wstrb_i = '0;
        status_i = '0;
        stall_en = 1'b0;
        for (int i = 0; i < CSR_CNT; i++) model[i] = '0;
        model[ON_THE_FLY_BALANCE] = 32'd100;
        model[CSR_VERSION_IDX] = CSR_VERSION;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < CSR_CNT; i++) read_check(i);
        check_outputs();
        finish_test("reset_values");

        for (int i = 0; i < RAND_WRITES; i++) begin
            idx = take_bits(4) % 6;
            data = take_bits(32);
            strb = take_bits(1) ? 4'hf : take_bits(4);
            axil_write(idx, data, strb, take_bits(2) % 3);
            model_write(idx, data, strb);
            read_check(idx);
            check_outputs();
        end
        finish_test("writable_registers");

        for (int i = 0; i < 6; i++) begin
            idx = RECORD_BUF_UPDATE + take_bits(1);
            data = take_bits(32);
            bu_cnt = 0;
            ff_cnt = 0;
            axil_write(idx, data, 4'hf, 2);
            n = 0;
            while (bu_cnt + ff_cnt == 0) begin
                @(posedge clk);
                if (++n > TIMEOUT) wait_timeout("a command pulse on cfg_o");
            end
            repeat (3) @(posedge clk);
            if (bu_cnt != (idx == RECORD_BUF_UPDATE)) begin
                report_mismatch("cfg_o.buf_update cycles", bu_cnt, idx == RECORD_BUF_UPDATE);
            end
            if (ff_cnt != (idx == RECORD_FORCE_FINISH)) begin
                report_mismatch("cfg_o.force_finish cycles", ff_cnt,
                                idx == RECORD_FORCE_FINISH);
            end
            read_check(idx);
        end
        finish_test("command_registers");

        drive_status();
        for (int i = RECORD_BITS_LO; i <= RR_STATE; i++) read_check(i);
        // read-only, version and reserved slots ignore host writes
        for (int i = RECORD_BITS_LO; i < CSR_CNT; i++) begin
            data = take_bits(32);
            axil_write(i, data, 4'hf, take_bits(2) % 3);
            read_check(i);
        end
        finish_test("read_only_registers");

        stall_en = 1'b1;
        for (int i = 0; i < STALL_OPS; i++) begin
            idx = take_bits(4);
            if (take_bits(1)) begin
                data = take_bits(32);
                strb = take_bits(4);
                axil_write(idx, data, strb, take_bits(2) % 3);
                model_write(idx, data, strb);
            end else begin
                read_check(idx);
            end
        end
        // let the last write reach the output pipe
        repeat (2) @(posedge clk);
        check_outputs();
        stall_en = 1'b0;
        finish_test("back_pressure");
        end_run();
    end

endmodule

//--- dv/rr_csr_props.sv
`timescale 1ns/1ps

module rr_csr_props (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                awready_o,
    input  logic                                bvalid_o,
    input  logic                                bready_i,
    input  logic [1:0]                          bresp_o,
    input  logic                                rvalid_o,
    input  logic                                rready_i,
    input  logic [rr_csr_pkg::CSR_DATA_W-1:0]   rdata_o,
    input  logic [1:0]                          rresp_o,
    input  rr_csr_pkg::storage_cfg_t            cfg_o
);

    int unsigned assert_fails = 0;

    // B and R stay up with stable payload until the host takes them
    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else begin
            assert_fails++;
            $error("bvalid_o or bresp_o changed before bready_i");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
        else begin
            assert_fails++;
            $error("rvalid_o, rdata_o or rresp_o changed before rready_i");
        end

    aw_stall: assert property (@(posedge clk) disable iff (!rstn)
        bvalid_o && !bready_i |-> !awready_o)
        else begin
            assert_fails++;
            $error("awready_o high while B is stalled");
        end

    bu_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cfg_o.buf_update |=> !cfg_o.buf_update)
        else begin
            assert_fails++;
            $error("buf_update longer than one cycle");
        end

    ff_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cfg_o.force_finish |=> !cfg_o.force_finish)
        else begin
            assert_fails++;
            $error("force_finish longer than one cycle");
        end

endmodule

bind rr_csr_top rr_csr_props u_props (.*);

//--- logic/rr_csr_top.sv
`timescale 1ns/1ps

module rr_csr_top (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                awvalid_i,
    input  logic [rr_csr_pkg::AXIL_ADDR_W-1:0]  awaddr_i,
    output logic                                awready_o,
    input  logic                                wvalid_i,
    input  logic [rr_csr_pkg::CSR_DATA_W-1:0]   wdata_i,
    input  logic [rr_csr_pkg::CSR_STRB_W-1:0]   wstrb_i,
    output logic                                wready_o,
    output logic                                bvalid_o,
    input  logic                                bready_i,
    output logic [1:0]                          bresp_o,
    input  logic                                arvalid_i,
    input  logic [rr_csr_pkg::AXIL_ADDR_W-1:0]  araddr_i,
    output logic                                arready_o,
    output logic                                rvalid_o,
    input  logic                                rready_i,
    output logic [rr_csr_pkg::CSR_DATA_W-1:0]   rdata_o,
    output logic [1:0]                          rresp_o,
    input  rr_csr_pkg::status_t                 status_i,
    output rr_csr_pkg::rr_mode_t                mode_o,
    output rr_csr_pkg::storage_cfg_t            cfg_o
);
    import rr_csr_pkg::*;

    logic [CSR_IDX_W-1:0]  rd_idx;
    logic [CSR_DATA_W-1:0] rd_data;
    status_t               status_q;
    rr_mode_t              mode;
    storage_cfg_t          cfg;

    csr_write_if wr_bus ();

    axil_write_capture u_capture (
        .clk       (clk),
        .rstn      (rstn),
        .awvalid_i (awvalid_i),
        .awaddr_i  (awaddr_i),
        .awready_o (awready_o),
        .wvalid_i  (wvalid_i),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wready_o  (wready_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .bresp_o   (bresp_o),
        .wr        (wr_bus)
    );

    // status is registered before it reaches the read mux
    lib_pipe #(.T(status_t), .STAGES(CSR_PIPE_STAGES)) u_status_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (status_i),
        .out_o (status_q)
    );

    csr_file u_file (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr_bus),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_data),
        .status_i  (status_q),
        .mode_o    (mode),
        .cfg_o     (cfg)
    );

    axil_read_port u_read (
        .clk       (clk),
        .rstn      (rstn),
        .arvalid_i (arvalid_i),
        .araddr_i  (araddr_i),
        .arready_o (arready_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rd_idx_o  (rd_idx),
        .rd_data_i (rd_data)
    );

    lib_pipe #(.T(rr_mode_t), .STAGES(CSR_PIPE_STAGES)) u_mode_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (mode),
        .out_o (mode_o)
    );

    lib_pipe #(.T(storage_cfg_t), .STAGES(CSR_PIPE_STAGES)) u_cfg_pipe (
        .clk   (clk),
        .rstn  (rstn),
        .in_i  (cfg),
        .out_o (cfg_o)
    );

endmodule

//--- logic/axil_read_port.sv
`timescale 1ns/1ps

module axil_read_port (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                arvalid_i,
    input  logic [rr_csr_pkg::AXIL_ADDR_W-1:0]  araddr_i,
    output logic                                arready_o,
    output logic                                rvalid_o,
    input  logic                                rready_i,
    output logic [rr_csr_pkg::CSR_DATA_W-1:0]   rdata_o,
    output logic [1:0]                          rresp_o,
    output logic [rr_csr_pkg::CSR_IDX_W-1:0]    rd_idx_o,
    input  logic [rr_csr_pkg::CSR_DATA_W-1:0]   rd_data_i
);
    import rr_csr_pkg::*;

    logic ar_fire;

    // no new address while a response sits unaccepted
    assign arready_o = ~(rvalid_o & ~rready_i);
    assign ar_fire = arvalid_i & arready_o;

    assign rd_idx_o = araddr_i[2 +: CSR_IDX_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid_o <= 1'b0;
        end else if (ar_fire) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_o <= rd_data_i;
        end
    end

    assign rresp_o = 2'b00;

endmodule

//--- logic/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                                clk,
    input  logic                                rstn,
    csr_write_if.buffer                         wr,
    input  logic [rr_csr_pkg::CSR_IDX_W-1:0]    rd_idx_i,
    output logic [rr_csr_pkg::CSR_DATA_W-1:0]   rd_data_o,
    input  rr_csr_pkg::status_t                 status_i,
    output rr_csr_pkg::rr_mode_t                mode_o,
    output rr_csr_pkg::storage_cfg_t            cfg_o
);
    import rr_csr_pkg::*;

    logic [CSR_DATA_W-1:0] csr_q [CSR_CNT];
    logic [CSR_DATA_W-1:0] csr_rd [CSR_CNT];

    logic [CSR_DATA_W-1:0] strb_mask;
    logic [CSR_DATA_W-1:0] merged;
    logic                  wr_writable;

    logic                  wr_en_q;
    logic [CSR_IDX_W-1:0]  wr_idx_q;
    logic [CSR_DATA_W-1:0] wr_word_q;

    logic buf_update;
    logic force_finish;

    always_comb begin
        for (int b = 0; b < CSR_STRB_W; b++) begin
            strb_mask[8*b +: 8] = {8{wr.wr_strb[b]}};
        end
    end

    // bytes with a clear strobe keep their old value
    assign merged = (strb_mask & wr.wr_data) | (~strb_mask & csr_q[wr.wr_idx]);

    // only the low slots hold host data
    assign wr_writable = (wr.wr_idx <= ON_THE_FLY_BALANCE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_en_q <= 1'b0;
            for (int i = 0; i < CSR_CNT; i++) begin
                csr_q[i] <= '0;
            end
            csr_q[ON_THE_FLY_BALANCE] <= BALANCE_RESET;
        end else begin
            wr_en_q <= wr.wr_valid & wr_writable;
            if (wr_en_q) begin
                csr_q[wr_idx_q] <= wr_word_q;
            end
        end
    end

    // first stage of the write, merged word waits here one cycle
    always_ff @(posedge clk) begin
        if (wr.wr_valid) begin
            wr_idx_q <= wr.wr_idx;
            wr_word_q <= merged;
        end
    end

    // command slots never store, they only fire a pulse
    assign buf_update = wr.wr_valid && (wr.wr_idx == RECORD_BUF_UPDATE);
    assign force_finish = wr.wr_valid && (wr.wr_idx == RECORD_FORCE_FINISH);

    // read-only slots mirror status and version every cycle
    always_comb begin
        csr_rd = csr_q;
        csr_rd[RECORD_BITS_LO] = status_i.record_bits[31:0];
        csr_rd[RECORD_BITS_HI] = status_i.record_bits[63:32];
        csr_rd[RR_STATE] = status_i.rr_state;
        csr_rd[CSR_VERSION_IDX] = CSR_VERSION;
    end

    assign rd_data_o = csr_rd[rd_idx_i];

    assign mode_o.record_en = csr_q[RR_MODE][0];
    assign mode_o.replay_en = csr_q[RR_MODE][1];
    assign mode_o.validate_en = csr_q[RR_MODE][2];

    assign cfg_o.buf_addr = {csr_q[BUF_ADDR_HI], csr_q[BUF_ADDR_LO]};
    assign cfg_o.buf_size = {csr_q[BUF_SIZE_HI], csr_q[BUF_SIZE_LO]};
    assign cfg_o.balance = csr_q[ON_THE_FLY_BALANCE];
    assign cfg_o.buf_update = buf_update;
    assign cfg_o.force_finish = force_finish;

endmodule

//--- logic/axil_write_capture.sv
`timescale 1ns/1ps

module axil_write_capture (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                awvalid_i,
    input  logic [rr_csr_pkg::AXIL_ADDR_W-1:0]  awaddr_i,
    output logic                                awready_o,
    input  logic                                wvalid_i,
    input  logic [rr_csr_pkg::CSR_DATA_W-1:0]   wdata_i,
    input  logic [rr_csr_pkg::CSR_STRB_W-1:0]   wstrb_i,
    output logic                                wready_o,
    output logic                                bvalid_o,
    input  logic                                bready_i,
    output logic [1:0]                          bresp_o,
    csr_write_if.producer                       wr
);
    import rr_csr_pkg::*;

    logic aw_fire, w_fire, write_done;
    logic aw_held, w_held;
    logic b_stall;
    logic wr_valid_q;

    logic [CSR_IDX_W-1:0]  idx_q;
    logic [CSR_DATA_W-1:0] data_q;
    logic [CSR_STRB_W-1:0] strb_q;

    assign aw_fire = awvalid_i & awready_o;
    assign w_fire = wvalid_i & wready_o;
    assign write_done = (aw_fire | aw_held) & (w_fire | w_held);

    assign b_stall = bvalid_o & ~bready_i;

    // hold off a new write while one channel waits for its partner,
    // while the strobe is out, or while B is stalled
    assign awready_o = ~aw_held & ~wr_valid_q & ~b_stall;
    assign wready_o = ~w_held & ~wr_valid_q & ~b_stall;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            wr_valid_q <= 1'b0;
            bvalid_o <= 1'b0;
        end else begin
            if (write_done) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else begin
                if (aw_fire) aw_held <= 1'b1;
                if (w_fire) w_held <= 1'b1;
            end
            wr_valid_q <= write_done;
            // response follows the strobe by one cycle
            if (wr_valid_q) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            idx_q <= awaddr_i[2 +: CSR_IDX_W];
        end
        if (w_fire) begin
            data_q <= wdata_i;
            strb_q <= wstrb_i;
        end
    end

    assign bresp_o = 2'b00;

    assign wr.wr_valid = wr_valid_q;
    assign wr.wr_idx = idx_q;
    assign wr.wr_data = data_q;
    assign wr.wr_strb = strb_q;

endmodule

//--- logic/lib_pipe.sv
`timescale 1ns/1ps

module lib_pipe #(
    parameter type T = logic,
    parameter int STAGES = 1
) (
    input  logic clk,
    input  logic rstn,
    input  T     in_i,
    output T     out_o
);

    T stage_q [STAGES];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= in_i;
            // shift towards the output end
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out_o = stage_q[STAGES-1];

endmodule

//--- logic/csr_write_if.sv
`timescale 1ns/1ps

interface csr_write_if;
    import rr_csr_pkg::*;

    // one accepted write, wr_valid lasts a single cycle
    logic                  wr_valid;
    logic [CSR_IDX_W-1:0]  wr_idx;
    logic [CSR_DATA_W-1:0] wr_data;
    logic [CSR_STRB_W-1:0] wr_strb;

    modport producer (
        output wr_valid, wr_idx, wr_data, wr_strb
    );

    modport buffer (
        input wr_valid, wr_idx, wr_data, wr_strb
    );

endinterface

//--- logic/rr_csr_pkg.sv
package rr_csr_pkg;

    localparam int CSR_CNT = 16;
    localparam int CSR_IDX_W = 4;
    localparam int CSR_DATA_W = 32;
    localparam int CSR_STRB_W = CSR_DATA_W / 8;
    localparam int AXIL_ADDR_W = 32;
    localparam int CSR_PIPE_STAGES = 1;

    localparam logic [CSR_DATA_W-1:0] CSR_VERSION = 32'h0001_0003;
    localparam logic [CSR_DATA_W-1:0] BALANCE_RESET = 32'd100;

    // word index, byte address bits 5:2
    typedef enum logic [CSR_IDX_W-1:0] {
        RR_MODE             = 4'd0,
        BUF_ADDR_LO         = 4'd1,
        BUF_ADDR_HI         = 4'd2,
        BUF_SIZE_LO         = 4'd3,
        BUF_SIZE_HI         = 4'd4,
        ON_THE_FLY_BALANCE  = 4'd5,
        RECORD_BUF_UPDATE   = 4'd6,
        RECORD_FORCE_FINISH = 4'd7,
        RECORD_BITS_LO      = 4'd8,
        RECORD_BITS_HI      = 4'd9,
        RR_STATE            = 4'd10,
        CSR_VERSION_IDX     = 4'd11
        // 12 to 15 reserved, read as zero
    } csr_idx_e;

    typedef struct packed {
        logic record_en;
        logic replay_en;
        logic validate_en;
    } rr_mode_t;

    typedef struct packed {
        logic [63:0] buf_addr;
        logic [63:0] buf_size;
        logic [31:0] balance;
        logic        buf_update;
        logic        force_finish;
    } storage_cfg_t;

    typedef struct packed {
        logic [63:0] record_bits;
        logic [31:0] rr_state;
    } status_t;

endpackage
